// ==== design/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcodes that the decoder recognizes. Anything else is illegal
  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'h03,
    OPCODE_MISC_MEM = 7'h0f,
    OPCODE_OP_IMM   = 7'h13,
    OPCODE_STORE    = 7'h23,
    OPCODE_OP       = 7'h33,
    OPCODE_LUI      = 7'h37,
    OPCODE_SYSTEM   = 7'h73
  } opcode_e;

  // CSR_OP_READ doubles as the no-effect value for non-CSR instructions
  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  typedef enum logic [2:0] {
    SYS_NONE   = 3'd0,
    SYS_ECALL  = 3'd1,
    SYS_EBREAK = 3'd2,
    SYS_MRET   = 3'd3,
    SYS_DRET   = 3'd4,
    SYS_WFI    = 3'd5,
    SYS_FENCEI = 3'd6
  } sys_e;

  // funct7 patterns of the OP and shift-immediate forms
  localparam logic [6:0] FUNCT7_BASE   = 7'b0000000;
  localparam logic [6:0] FUNCT7_ALT    = 7'b0100000;
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // Bits [31:20] of the privileged instructions under funct3 000
  localparam logic [11:0] SYS_IMM_ECALL  = 12'h000;
  localparam logic [11:0] SYS_IMM_EBREAK = 12'h001;
  localparam logic [11:0] SYS_IMM_WFI    = 12'h105;
  localparam logic [11:0] SYS_IMM_MRET   = 12'h302;
  localparam logic [11:0] SYS_IMM_DRET   = 12'h7b2;

  ////////////////////
  // Pipe payloads
  ////////////////////

  typedef struct packed {
    logic [31:0] instr;
    logic        illegal_c;
  } if_id_pipe_t;

  typedef struct packed {
    logic        alu_en;
    logic        mul_en;
    logic        lsu_en;
    logic        rf_we;
    csr_op_e     csr_op;
    sys_e        sys;
    logic        illegal;
    logic [4:0]  rd;
    logic [31:0] imm;
  } id_ex_pipe_t;

endpackage

`default_nettype wire

// ==== design/pipe_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Valid/ready link between two pipeline stages
// The payload holds steady from the source until valid and ready meet on an edge
interface pipe_if #(
  parameter type payload_t = logic
);

  logic     valid;
  logic     ready;
  // Controller requests on the receiving stage
  logic     halt;
  logic     kill;
  payload_t payload;

  modport src (
    output valid,
    output payload,
    input  ready
  );

  // halt and kill come from outside and are only looked at by the receiver
  modport dst (
    input  valid,
    input  payload,
    input  halt,
    input  kill,
    output ready
  );

endinterface

`default_nettype wire

// ==== design/pipe_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

// One-entry pipeline register with valid/ready on both sides
// Halt and kill come with the upstream link
module pipe_reg
  import decode_pkg::*;
#(
  parameter type payload_t = if_id_pipe_t
) (
  input logic clk,
  input logic arst_n,
  pipe_if.dst up,
  pipe_if.src down
);

  logic     full;
  logic     load;
  payload_t data;

  ////////////////////
  // Upstream side
  ////////////////////

  // Kill makes the stage swallow the incoming item, so it reports ready
  // Halt freezes the stage, so it does not
  // Otherwise there is room when empty or when the entry leaves on this edge
  assign up.ready = up.kill ? 1'b1 :
                    up.halt ? 1'b0 :
                    (!full || down.ready);

  // Nothing is captured while halted or killed
  assign load = up.valid && up.ready && !up.kill && !up.halt;

  ////////////////////
  // Storage
  ////////////////////

  // Stays full on a new load, drains when the downstream takes the entry
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      full <= 1'b0;
    end else begin
      full <= load || (full && !down.ready);
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      data <= up.payload;
    end
  end

  ////////////////////
  // Downstream side
  ////////////////////

  assign down.valid   = full;
  assign down.payload = data;

endmodule

`default_nettype wire

// ==== design/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

// Purely combinational decode of one IF/ID entry into the ID/EX control bundle
module instr_decoder
  import decode_pkg::*;
#(
  parameter bit M_EXT = 1'b1
) (
  input  if_id_pipe_t in,
  output id_ex_pipe_t out
);

  logic [6:0]  opcode;
  logic [4:0]  rd;
  logic [2:0]  funct3;
  logic [4:0]  rs1;
  logic [6:0]  funct7;
  logic [11:0] sys_imm;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_u;
  logic [31:0] imm_csr;
  logic        unknown;
  id_ex_pipe_t dec;

  ////////////////////
  // Fields
  ////////////////////

  assign opcode  = in.instr[6:0];
  assign rd      = in.instr[11:7];
  assign funct3  = in.instr[14:12];
  assign rs1     = in.instr[19:15];
  assign funct7  = in.instr[31:25];
  assign sys_imm = in.instr[31:20];

  assign imm_i   = {{20{in.instr[31]}}, in.instr[31:20]};
  assign imm_s   = {{20{in.instr[31]}}, in.instr[31:25], in.instr[11:7]};
  assign imm_u   = {in.instr[31:12], 12'b0};
  // The CSR address travels zero-extended in the immediate
  assign imm_csr = {20'b0, in.instr[31:20]};

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    dec     = '0;
    unknown = 1'b0;
    case (opcode)
      OPCODE_OP: begin
        dec.rf_we = 1'b1;
        dec.rd    = rd;
        if (funct7 == FUNCT7_BASE) begin
          dec.alu_en = 1'b1;
        end else if (funct7 == FUNCT7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          // SUB and SRA
          dec.alu_en = 1'b1;
        end else if (funct7 == FUNCT7_MULDIV && M_EXT) begin
          // All eight M forms go to the multiplier
          dec.mul_en = 1'b1;
        end else begin
          unknown = 1'b1;
        end
      end
      OPCODE_OP_IMM: begin
        dec.alu_en = 1'b1;
        dec.rf_we  = 1'b1;
        dec.rd     = rd;
        dec.imm    = imm_i;
        // Shift immediates constrain the upper bits, the rest take any immediate
        if (funct3 == 3'b001 && funct7 != FUNCT7_BASE) begin
          unknown = 1'b1;
        end else if (funct3 == 3'b101 && funct7 != FUNCT7_BASE && funct7 != FUNCT7_ALT) begin
          unknown = 1'b1;
        end
      end
      OPCODE_LOAD: begin
        dec.lsu_en = 1'b1;
        dec.rf_we  = 1'b1;
        dec.rd     = rd;
        dec.imm    = imm_i;
        // LB, LH, LW, LBU and LHU
        unknown    = (funct3 == 3'b011) || (funct3 == 3'b110) || (funct3 == 3'b111);
      end
      OPCODE_STORE: begin
        dec.lsu_en = 1'b1;
        dec.imm    = imm_s;
        unknown    = (funct3 > 3'b010);
      end
      OPCODE_LUI: begin
        dec.alu_en = 1'b1;
        dec.rf_we  = 1'b1;
        dec.rd     = rd;
        dec.imm    = imm_u;
      end
      OPCODE_MISC_MEM: begin
        // Only FENCE.I is handled, plain FENCE is not part of the decoded set
        dec.sys = SYS_FENCEI;
        unknown = (funct3 != 3'b001);
      end
      OPCODE_SYSTEM: begin
        case (funct3)
          3'b000: begin
            // Privileged forms carry no registers
            case (sys_imm)
              SYS_IMM_ECALL:  dec.sys = SYS_ECALL;
              SYS_IMM_EBREAK: dec.sys = SYS_EBREAK;
              SYS_IMM_MRET:   dec.sys = SYS_MRET;
              SYS_IMM_DRET:   dec.sys = SYS_DRET;
              SYS_IMM_WFI:    dec.sys = SYS_WFI;
              default:        unknown = 1'b1;
            endcase
            if (rs1 != 5'd0 || rd != 5'd0) begin
              unknown = 1'b1;
            end
          end
          3'b001, 3'b010, 3'b011: begin
            dec.rf_we = 1'b1;
            dec.rd    = rd;
            dec.imm   = imm_csr;
            if (funct3 == 3'b001) begin
              dec.csr_op = CSR_OP_WRITE;
            end else if (rs1 == 5'd0) begin
              // CSRRS and CSRRC with x0 only read the CSR
              dec.csr_op = CSR_OP_READ;
            end else if (funct3 == 3'b010) begin
              dec.csr_op = CSR_OP_SET;
            end else begin
              dec.csr_op = CSR_OP_CLEAR;
            end
          end
          default: unknown = 1'b1;
        endcase
      end
      // Branches, jumps, AUIPC and the rest land here
      default: unknown = 1'b1;
    endcase
  end

  ////////////////////
  // Illegal handling
  ////////////////////

  // All no-effect values encode as zero, so an illegal bundle is zero apart from the flag
  always_comb begin
    if (unknown || in.illegal_c) begin
      out         = '0;
      out.illegal = 1'b1;
    end else begin
      out = dec;
    end
  end

endmodule

`default_nettype wire

// ==== design/id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

// Decode stage
// The IF/ID entry is decoded in this cycle and lands in the ID/EX register
module id_stage
  import decode_pkg::*;
#(
  parameter bit M_EXT = 1'b1
) (
  input logic clk,
  input logic arst_n,
  pipe_if.dst if_id,
  pipe_if.src id_ex
);

  id_ex_pipe_t dec_bundle;

  // Link from the decoder into the ID/EX register
  pipe_if #(.payload_t(id_ex_pipe_t)) dec_if ();

  ////////////////////
  // Decode
  ////////////////////

  instr_decoder #(
    .M_EXT (M_EXT)
  ) u_decoder (
    .in  (if_id.payload),
    .out (dec_bundle)
  );

  ////////////////////
  // Halt and kill
  ////////////////////

  // Under halt or kill the entry is never forwarded
  assign dec_if.valid   = if_id.valid && !if_id.halt && !if_id.kill;
  assign dec_if.payload = dec_bundle;
  // The register sees the same requests so its own ready follows the same rules
  assign dec_if.halt    = if_id.halt;
  assign dec_if.kill    = if_id.kill;

  // Kill drops the entry upstream, halt keeps it there
  assign if_id.ready = if_id.kill ? 1'b1 :
                       if_id.halt ? 1'b0 :
                       dec_if.ready;

  ////////////////////
  // ID/EX register
  ////////////////////

  pipe_reg #(
    .payload_t (id_ex_pipe_t)
  ) u_id_ex_reg (
    .clk    (clk),
    .arst_n (arst_n),
    .up     (dec_if),
    .down   (id_ex)
  );

endmodule

`default_nettype wire

// ==== design/decode_top.sv ====
`timescale 1ns/100ps
`default_nettype none

// IF/ID register followed by the ID stage, with plain ports on both ends
module decode_top
  import decode_pkg::*;
#(
  parameter bit M_EXT = 1'b1
) (
  input  logic        clk,
  input  logic        arst_n,
  // Fetch side
  input  logic        in_valid,
  input  logic [31:0] in_instr,
  input  logic        in_illegal_c,
  output logic        in_ready,
  // Controller requests on ID
  input  logic        halt_id,
  input  logic        kill_id,
  // Execute side
  input  logic        ex_ready,
  output logic        out_valid,
  output logic        out_alu_en,
  output logic        out_mul_en,
  output logic        out_lsu_en,
  output logic        out_rf_we,
  output csr_op_e     out_csr_op,
  output sys_e        out_sys,
  output logic        out_illegal,
  output logic [4:0]  out_rd,
  output logic [31:0] out_imm
);

  pipe_if #(.payload_t(if_id_pipe_t)) if_id ();
  pipe_if #(.payload_t(if_id_pipe_t)) id_in ();
  pipe_if #(.payload_t(id_ex_pipe_t)) id_ex ();

  ////////////////////
  // Fetch into IF/ID
  ////////////////////

  assign if_id.valid             = in_valid;
  assign if_id.payload.instr     = in_instr;
  assign if_id.payload.illegal_c = in_illegal_c;
  // The IF/ID register itself is never halted or killed
  assign if_id.halt              = 1'b0;
  assign if_id.kill              = 1'b0;
  assign in_ready                = if_id.ready;

  pipe_reg #(
    .payload_t (if_id_pipe_t)
  ) u_if_id_reg (
    .clk    (clk),
    .arst_n (arst_n),
    .up     (if_id),
    .down   (id_in)
  );

  ////////////////////
  // ID stage
  ////////////////////

  assign id_in.halt = halt_id;
  assign id_in.kill = kill_id;

  id_stage #(
    .M_EXT (M_EXT)
  ) u_id_stage (
    .clk    (clk),
    .arst_n (arst_n),
    .if_id  (id_in),
    .id_ex  (id_ex)
  );

  ////////////////////
  // ID/EX out to execute
  ////////////////////

  assign id_ex.ready = ex_ready;
  assign id_ex.halt  = 1'b0;
  assign id_ex.kill  = 1'b0;

  assign out_valid   = id_ex.valid;
  assign out_alu_en  = id_ex.payload.alu_en;
  assign out_mul_en  = id_ex.payload.mul_en;
  assign out_lsu_en  = id_ex.payload.lsu_en;
  assign out_rf_we   = id_ex.payload.rf_we;
  assign out_csr_op  = id_ex.payload.csr_op;
  assign out_sys     = id_ex.payload.sys;
  assign out_illegal = id_ex.payload.illegal;
  assign out_rd      = id_ex.payload.rd;
  assign out_imm     = id_ex.payload.imm;

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/100ps
`default_nettype none

// Free-running clock and an active-low reset that releases after a few rising edges
module tb_clock #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release lands just after an edge so it never races the flops
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/id_stage_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

// Rules on the ID stage, bound into every id_stage instance
module id_stage_assertions
  import decode_pkg::*;
(
  input logic        clk,
  input logic        arst_n,
  input logic        valid,
  input logic        halt,
  input logic        kill,
  input logic        ready,
  input logic        fwd_valid,
  input id_ex_pipe_t bundle
);

  // A rejected word must reach EX with no side effect left
  no_effect_when_illegal: assert property (@(posedge clk) disable iff (!arst_n)
    (valid && bundle.illegal) |-> (!bundle.alu_en && !bundle.mul_en && !bundle.lsu_en &&
      !bundle.rf_we && bundle.csr_op == CSR_OP_READ && bundle.sys == SYS_NONE))
    else $error("illegal bundle still carries a side effect");

  // Halt freezes ID in both directions
  halt_blocks_id: assert property (@(posedge clk) disable iff (!arst_n)
    halt |-> (!ready && !fwd_valid))
    else $error("ID is ready or forwarding while halted");

  halt_kill_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
    !(halt && kill))
    else $error("halt and kill are high together");

endmodule

bind id_stage id_stage_assertions u_assertions (
  .clk       (clk),
  .arst_n    (arst_n),
  .valid     (if_id.valid),
  .halt      (if_id.halt),
  .kill      (if_id.kill),
  .ready     (if_id.ready),
  .fwd_valid (dec_if.valid),
  .bundle    (dec_bundle)
);

`default_nettype wire

// ==== test/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

////////////////////
// Reference decode
////////////////////

// Expected ID/EX bundle for one IF/ID entry, M extension enabled
function automatic id_ex_pipe_t ref_decode(input if_id_pipe_t e);
  id_ex_pipe_t r;
  logic        ok;
  logic [31:0] w;
  logic [2:0]  f3;
  logic [6:0]  f7;
  r  = '0;
  ok = 1'b1;
  w  = e.instr;
  f3 = w[14:12];
  f7 = w[31:25];
  case (w[6:0])
    7'h33: begin
      ok       = (f7 == 7'h00) || (f7 == 7'h01) ||
                 (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      r.alu_en = (f7 != 7'h01);
      r.mul_en = (f7 == 7'h01);
      r.rf_we  = 1'b1;
      r.rd     = w[11:7];
    end
    7'h13: begin
      // SLLI needs a zero top field, SRLI and SRAI allow only the two shift kinds
      ok       = !(f3 == 3'd1 && f7 != 7'h00) &&
                 !(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
      r.alu_en = 1'b1;
      r.rf_we  = 1'b1;
      r.rd     = w[11:7];
      r.imm    = {{20{w[31]}}, w[31:20]};
    end
    7'h03: begin
      ok       = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      r.lsu_en = 1'b1;
      r.rf_we  = 1'b1;
      r.rd     = w[11:7];
      r.imm    = {{20{w[31]}}, w[31:20]};
    end
    7'h23: begin
      ok       = (f3 <= 3'd2);
      r.lsu_en = 1'b1;
      r.imm    = {{20{w[31]}}, w[31:25], w[11:7]};
    end
    7'h37: begin
      r.alu_en = 1'b1;
      r.rf_we  = 1'b1;
      r.rd     = w[11:7];
      r.imm    = {w[31:12], 12'd0};
    end
    7'h0f: begin
      ok    = (f3 == 3'd1);
      r.sys = SYS_FENCEI;
    end
    7'h73: begin
      if (f3 == 3'd0) begin
        case (w[31:20])
          12'h000: r.sys = SYS_ECALL;
          12'h001: r.sys = SYS_EBREAK;
          12'h105: r.sys = SYS_WFI;
          12'h302: r.sys = SYS_MRET;
          12'h7b2: r.sys = SYS_DRET;
          default: ok = 1'b0;
        endcase
        // Privileged forms must name x0 on both sides
        if (w[19:15] != 5'd0 || w[11:7] != 5'd0) begin
          ok = 1'b0;
        end
      end else if (f3 <= 3'd3) begin
        r.rf_we = 1'b1;
        r.rd    = w[11:7];
        r.imm   = {20'd0, w[31:20]};
        if (f3 == 3'd1) begin
          r.csr_op = CSR_OP_WRITE;
        end else if (w[19:15] == 5'd0) begin
          r.csr_op = CSR_OP_READ;
        end else begin
          r.csr_op = (f3 == 3'd2) ? CSR_OP_SET : CSR_OP_CLEAR;
        end
      end else begin
        ok = 1'b0;
      end
    end
    default: ok = 1'b0;
  endcase
  // A rejected word keeps only its illegal flag
  if (!ok || e.illegal_c) begin
    r         = '0;
    r.illegal = 1'b1;
  end
  return r;
endfunction

////////////////////
// Slot tracking
////////////////////

// Slot 1 is the IF/ID register, slot 2 the ID/EX register
logic        s1_full;
if_id_pipe_t s1_data;
logic        s2_full;
id_ex_pipe_t s2_data;

task automatic clear_slots();
  s1_full = 1'b0;
  s2_full = 1'b0;
  s1_data = '0;
  s2_data = '0;
endtask

// Whether ID takes its entry this cycle (kill swallows it, halt keeps it)
function automatic logic id_accepts(input logic halt, input logic kill, input logic rdy);
  if (kill) begin
    return 1'b1;
  end
  if (halt) begin
    return 1'b0;
  end
  return !s2_full || rdy;
endfunction

// One clock edge of both registers, from the inputs seen before that edge
task automatic advance_slots(input logic v, input if_id_pipe_t word,
                             input logic halt, input logic kill, input logic rdy);
  logic take_id;
  logic load1;
  logic load2;
  take_id = id_accepts(halt, kill, rdy);
  load2   = s1_full && take_id && !halt && !kill;
  load1   = v && (!s1_full || take_id);
  if (load2) begin
    s2_data = ref_decode(s1_data);
  end
  s2_full = load2 || (s2_full && !rdy);
  if (load1) begin
    s1_data = word;
  end
  s1_full = load1 || (s1_full && !take_id);
endtask

`endif

// ==== test/decode_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module decode_tb
  import decode_pkg::*;
;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_CYCLES = 3000;
  // Random cycles plus the directed start and the drain at the end
  localparam int RUN_LIMIT  = (NUM_CYCLES + 100) * CLK_PERIOD;

  logic        clk;
  logic        arst_n;
  logic        in_valid;
  logic [31:0] in_instr;
  logic        in_illegal_c;
  logic        in_ready;
  logic        halt_id;
  logic        kill_id;
  logic        ex_ready;
  logic        out_valid;
  logic        out_alu_en;
  logic        out_mul_en;
  logic        out_lsu_en;
  logic        out_rf_we;
  csr_op_e     out_csr_op;
  sys_e        out_sys;
  logic        out_illegal;
  logic [4:0]  out_rd;
  logic [31:0] out_imm;
  id_ex_pipe_t seen;

  logic [31:0] rng;
  logic        held;
  int          beats;
  int          error_count;

  `include "decode_model.svh"

  tb_clock #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (3)
  ) u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  decode_top #(
    .M_EXT (1'b1)
  ) DUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .in_instr     (in_instr),
    .in_illegal_c (in_illegal_c),
    .in_ready     (in_ready),
    .halt_id      (halt_id),
    .kill_id      (kill_id),
    .ex_ready     (ex_ready),
    .out_valid    (out_valid),
    .out_alu_en   (out_alu_en),
    .out_mul_en   (out_mul_en),
    .out_lsu_en   (out_lsu_en),
    .out_rf_we    (out_rf_we),
    .out_csr_op   (out_csr_op),
    .out_sys      (out_sys),
    .out_illegal  (out_illegal),
    .out_rd       (out_rd),
    .out_imm      (out_imm)
  );

  // Output ports regrouped in bundle order
  assign seen = {out_alu_en, out_mul_en, out_lsu_en, out_rf_we, out_csr_op, out_sys,
                 out_illegal, out_rd, out_imm};

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic roll(output logic [31:0] v);
    rng = xorshift32(rng);
    v   = rng;
  endtask

  task automatic stop_on_error(input string why);
    error_count++;
    $display("ERROR at %0t: %s", $time, why);
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
      stop_on_error("value mismatch");
    end
  endtask

  // Random word biased towards the decoded classes with some branch, AUIPC and noise words
  task automatic pick_instr(output logic [31:0] w);
    logic [31:0] k;
    roll(w);
    roll(k);
    case (k[3:0])
      4'd0, 4'd1: begin
        w[6:0] = 7'h33;
        case (k[5:4])
          2'd0: w[31:25] = 7'h00;
          2'd1: w[31:25] = 7'h20;
          2'd2: w[31:25] = 7'h01;
          default: ;
        endcase
      end
      4'd2, 4'd3: begin
        w[6:0] = 7'h13;
        if (k[4]) begin
          w[31:25] = k[5] ? 7'h20 : 7'h00;
        end
      end
      4'd4: w[6:0] = 7'h03;
      4'd5: w[6:0] = 7'h23;
      4'd6: w[6:0] = 7'h37;
      4'd7, 4'd8: begin
        // CSR forms where rs1 is sometimes x0
        w[6:0]   = 7'h73;
        w[14:12] = (k[5:4] == 2'd0) ? 3'd1 : {1'b0, k[5:4]};
        if (k[6]) begin
          w[19:15] = 5'd0;
        end
      end
      4'd9, 4'd10: begin
        w[6:0]   = 7'h73;
        w[14:12] = 3'd0;
        if (!k[7]) begin
          w[11:7]  = 5'd0;
          w[19:15] = 5'd0;
        end
        case (k[6:4])
          3'd0: w[31:20] = 12'h000;
          3'd1: w[31:20] = 12'h001;
          3'd2: w[31:20] = 12'h105;
          3'd3: w[31:20] = 12'h302;
          3'd4: w[31:20] = 12'h7b2;
          default: ;
        endcase
      end
      4'd11: begin
        w[6:0] = 7'h0f;
        if (!k[4]) begin
          w[14:12] = 3'd1;
        end
      end
      4'd12: w[6:0] = 7'h63;
      4'd13: w[6:0] = 7'h17;
      default: ;
    endcase
  endtask

  // Compare the DUT against the slots before the coming edge
  task automatic check_outputs();
    check_eq("out_valid", 64'(out_valid), 64'(s2_full));
    check_eq("in_ready", 64'(in_ready),
             64'(!s1_full || id_accepts(halt_id, kill_id, ex_ready)));
    if (s2_full) begin
      check_eq("ID/EX bundle", 64'(seen), 64'(s2_data));
    end
  endtask

  // One clock cycle that starts just after a rising edge
  task automatic run_cycle(input bit drain);
    logic [31:0] r;
    if_id_pipe_t word;
    roll(r);
    if (drain) begin
      in_valid = held;
      halt_id  = 1'b0;
      kill_id  = 1'b0;
      ex_ready = 1'b1;
    end else begin
      // A word that was not taken stays on the inputs
      if (!held) begin
        in_valid     = (r[1:0] != 2'b00);
        in_illegal_c = (r[11:8] == 4'd0);
        pick_instr(in_instr);
      end
      ex_ready = (r[4:2] > 3'd1);
      halt_id  = (r[7:5] == 3'd0);
      kill_id  = (r[7:5] == 3'd1);
    end
    @(negedge clk);
    check_outputs();
    if (out_valid && ex_ready) begin
      beats++;
    end
    held       = in_valid && !in_ready;
    word.instr     = in_instr;
    word.illegal_c = in_illegal_c;
    advance_slots(in_valid, word, halt_id, kill_id, ex_ready);
    @(posedge clk);
    #1;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    if_id_pipe_t lui;
    int          lat;
    in_valid     = 1'b0;
    in_instr     = 32'd0;
    in_illegal_c = 1'b0;
    halt_id      = 1'b0;
    kill_id      = 1'b0;
    ex_ready     = 1'b0;
    rng          = 32'd64;
    held         = 1'b0;
    beats        = 0;
    error_count  = 0;
    clear_slots();

    @(posedge arst_n);
    @(negedge clk);
    check_eq("out_valid after reset", 64'(out_valid), 64'd0);
    check_eq("in_ready after reset", 64'(in_ready), 64'd1);
    @(posedge clk);
    #1;

    // Single LUI through an idle pipe to measure the latency
    lui.instr     = {20'h12345, 5'd5, 7'h37};
    lui.illegal_c = 1'b0;
    in_instr      = lui.instr;
    in_valid      = 1'b1;
    ex_ready      = 1'b1;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    lat      = 1;
    @(negedge clk);
    while (!out_valid && lat < 8) begin
      @(negedge clk);
      lat++;
    end
    if (!out_valid) begin
      stop_on_error("the directed LUI never reached out_valid");
    end
    check_eq("edges from accept to output", 64'(lat), 64'd2);
    check_eq("directed LUI bundle", 64'(seen), 64'(ref_decode(lui)));
    @(posedge clk);
    #1;

    repeat (NUM_CYCLES) begin
      run_cycle(1'b0);
    end
    // Let everything still in flight come out
    repeat (6) begin
      run_cycle(1'b1);
    end
    // Nothing may be left over or repeated once the drain is over
    @(negedge clk);
    check_eq("out_valid after drain", 64'(out_valid), 64'd0);
    if (beats < 200) begin
      stop_on_error("too few beats reached the execute side");
    end

    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(RUN_LIMIT);
    stop_on_error("the run did not finish in time");
  end

endmodule

`default_nettype wire

// ==== tb.f ====
design/decode_pkg.sv
design/pipe_if.sv
design/pipe_reg.sv
design/instr_decoder.sv
design/id_stage.sv
design/decode_top.sv
+incdir+test
test/tb_clock.sv
test/id_stage_assertions.sv
test/decode_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --assert -f tb.f --top-module decode_tb -o decode_sim \
  && ./obj_dir/decode_sim | tee /dev/stderr | grep -F "Simulation passed" > /dev/null \
  || { echo "run did not pass"; exit 1; }
